//--- Makefile
VERILATOR ?= verilator
TOP       ?= scurve_tb
RTL_TOP   ?= scurve_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
hdl/scurve_pkg.sv
hdl/pulse_sync.sv
hdl/scurve_counter.sv
hdl/scurve_fifo.sv
hdl/scurve_apb_regs.sv
hdl/scurve_top.sv
verification/tb_clock.sv
verification/scurve_tb.sv

//--- hdl/pulse_sync.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_sync #(
  parameter bit FALLING = 1'b1
) (
  input  logic clk_n,
  input  logic reset_n,
  input  logic async_in,
  output logic edge_pulse
);
  import scurve_pkg::*;

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   last_q;
  logic                   cur;

  // Newest synchronized sample
  assign cur = sync_q[SYNC_STAGES-1];

  // Reset to the idle level of the line, high for active-low triggers
  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      sync_q <= {SYNC_STAGES{FALLING}};
      last_q <= FALLING;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], async_in};
      last_q <= cur;
    end
  end

  // One pulse per transition, however long the line stays at its new level
  always_comb begin
    if (FALLING) begin
      edge_pulse = last_q & ~cur;
    end else begin
      edge_pulse = ~last_q & cur;
    end
  end

endmodule

`default_nettype wire

//--- hdl/scurve_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scurve_apb_regs (
  input  logic                  clk_n,
  input  logic                  reset_n,
  input  scurve_pkg::apb_addr_t paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  scurve_pkg::apb_data_t pwdata,
  input  logic                  busy,
  input  logic                  done,
  input  scurve_pkg::count_t    rd_data,
  input  logic                  empty,
  input  scurve_pkg::level_t    level,
  output scurve_pkg::apb_data_t prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  start,
  output scurve_pkg::count_t    cpt_max,
  output logic                  rd_en
);
  import scurve_pkg::*;

  logic done_q;
  logic access;
  logic wr_acc;
  logic rd_acc;
  logic mapped;
  logic data_err;

  // Every transfer completes in its access phase
  assign pready = 1'b1;

  assign access = psel && penable;
  assign wr_acc = access && pwrite;
  assign rd_acc = access && !pwrite;

  assign mapped = (paddr == ADDR_CTRL) || (paddr == ADDR_CPT_MAX) ||
                  (paddr == ADDR_STATUS) || (paddr == ADDR_DATA);

  assign data_err = rd_acc && (paddr == ADDR_DATA) && empty;
  assign pslverr  = (access && !mapped) || data_err;

  // Start pulse lands in the access cycle, so busy follows one cycle later
  assign start = wr_acc && (paddr == ADDR_CTRL) && pwdata[0];

  // Pop only on a DATA read that actually returns a word
  assign rd_en = rd_acc && (paddr == ADDR_DATA) && !empty;

  always_comb begin
    case (paddr)
      ADDR_CTRL:    prdata = {30'b0, done_q, busy};
      ADDR_CPT_MAX: prdata = {16'b0, cpt_max};
      ADDR_STATUS:  prdata = {24'b0, level, 3'b0, empty};
      ADDR_DATA:    prdata = empty ? '0 : {16'b0, rd_data};
      default:      prdata = '0;
    endcase
  end

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      cpt_max <= CPT_MAX_RESET;
    end else if (wr_acc && (paddr == ADDR_CPT_MAX)) begin
      cpt_max <= pwdata[15:0];
    end
  end

  // Sticky done, a completion in the same cycle as a clear wins
  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      done_q <= 1'b0;
    end else if (done) begin
      done_q <= 1'b1;
    end else if (wr_acc && (paddr == ADDR_CTRL) && pwdata[1]) begin
      done_q <= 1'b0;
    end
  end

  a_penable_needs_psel: assert property (
    @(posedge clk_n) disable iff (!reset_n) penable |-> psel
  );

endmodule

`default_nettype wire

//--- hdl/scurve_counter.sv
`timescale 1ns/1ps
`default_nettype none

module scurve_counter (
  input  logic               clk_n,
  input  logic               reset_n,
  input  logic               start,
  input  scurve_pkg::count_t cpt_max,
  input  logic               inj_edge,
  input  logic [2:0]         trig_edge,
  input  logic               full,
  output logic               busy,
  output logic               done,
  output logic               wr_en,
  output scurve_pkg::count_t wr_data
);
  import scurve_pkg::*;

  counter_state_t state;
  count_t         inj_cnt;
  count_t         inj_next;
  count_t         cpt_max_q;
  count_t         trig_cnt [WORDS_PER_RESULT];
  logic           in_write;
  logic           last_inj;
  logic           accept_start;

  assign accept_start = (state == idle) && start;
  assign inj_next     = inj_cnt + count_t'(1);
  assign last_inj     = inj_edge && (inj_next == cpt_max_q);
  assign in_write     = (state == write_t0) || (state == write_t1) || (state == write_t2);
  assign busy         = (state != idle);

  // Hold the current word while the FIFO is full
  assign wr_en = in_write && !full;

  // Result words leave in trigger order
  always_comb begin
    case (state)
      write_t1: wr_data = trig_cnt[1];
      write_t2: wr_data = trig_cnt[2];
      default:  wr_data = trig_cnt[0];
    endcase
  end

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      state   <= idle;
      inj_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            inj_cnt <= '0;
            // Zero injections means an empty window
            if (cpt_max == '0) begin
              state <= write_t0;
            end else begin
              state <= run;
            end
          end
        end
        run: begin
          if (inj_edge) begin
            inj_cnt <= inj_next;
            if (last_inj) begin
              state <= write_t0;
            end
          end
        end
        write_t0: begin
          if (wr_en) begin
            state <= write_t1;
          end
        end
        write_t1: begin
          if (wr_en) begin
            state <= write_t2;
          end
        end
        write_t2: begin
          if (wr_en) begin
            state <= idle;
            done  <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Trigger counts include the cycle of the last injection edge
  always_ff @(posedge clk_n) begin
    if (accept_start) begin
      cpt_max_q <= cpt_max;
      for (int i = 0; i < WORDS_PER_RESULT; i++) begin
        trig_cnt[i] <= '0;
      end
    end else if (state == run) begin
      for (int i = 0; i < WORDS_PER_RESULT; i++) begin
        if (trig_edge[i]) begin
          trig_cnt[i] <= trig_cnt[i] + count_t'(1);
        end
      end
    end
  end

  // A stalled word must not change before the FIFO takes it
  a_stall_holds_word: assert property (
    @(posedge clk_n) disable iff (!reset_n) (in_write && full) |=> $stable(wr_data)
  );

  // A longer injection pulse would count one edge twice
  a_inj_edge_single: assert property (
    @(posedge clk_n) disable iff (!reset_n) inj_edge |=> !inj_edge
  );

endmodule

`default_nettype wire

//--- hdl/scurve_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module scurve_fifo (
  input  logic               clk_n,
  input  logic               reset_n,
  input  logic               wr_en,
  input  scurve_pkg::count_t wr_data,
  input  logic               rd_en,
  output scurve_pkg::count_t rd_data,
  output logic               full,
  output logic               empty,
  output scurve_pkg::level_t level
);
  import scurve_pkg::*;

  count_t                mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic                  do_wr;
  logic                  do_rd;

  assign full  = (level == level_t'(FIFO_DEPTH));
  assign empty = (level == '0);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Show-ahead head
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk_n) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   level <= level + level_t'(1);
        2'b01:   level <= level - level_t'(1);
        default: level <= level;
      endcase
    end
  end

  a_no_overflow: assert property (
    @(posedge clk_n) disable iff (!reset_n) wr_en |-> !full
  );

  a_no_underflow: assert property (
    @(posedge clk_n) disable iff (!reset_n) rd_en |-> !empty
  );

endmodule

`default_nettype wire

//--- hdl/scurve_pkg.sv
`default_nettype none

package scurve_pkg;

  // Injection and trigger counts, also the width of one result word
  typedef logic [15:0] count_t;

  // APB byte address and data word
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // FIFO occupancy, 0 up to FIFO_DEPTH inclusive
  typedef logic [3:0]  level_t;

  // Counter FSM states
  typedef enum logic [2:0] {
    idle,
    run,
    write_t0,
    write_t1,
    write_t2
  } counter_state_t;

  // Result buffer geometry
  localparam int FIFO_DEPTH       = 8;
  localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
  localparam int WORDS_PER_RESULT = 3;

  // Injections per measurement after reset
  localparam count_t CPT_MAX_RESET = 16'd100;

  // Flops in each input synchronizer
  localparam int SYNC_STAGES = 2;

  // APB register map
  localparam apb_addr_t ADDR_CTRL    = 4'h0;
  localparam apb_addr_t ADDR_CPT_MAX = 4'h4;
  localparam apb_addr_t ADDR_STATUS  = 4'h8;
  localparam apb_addr_t ADDR_DATA    = 4'hC;

endpackage

`default_nettype wire

//--- hdl/scurve_top.sv
`timescale 1ns/1ps
`default_nettype none

module scurve_top (
  input  logic                  clk_n,
  input  logic                  reset_n,
  input  logic                  ext_clk,
  input  logic                  trigger0b,
  input  logic                  trigger1b,
  input  logic                  trigger2b,
  input  scurve_pkg::apb_addr_t paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  scurve_pkg::apb_data_t pwdata,
  output scurve_pkg::apb_data_t prdata,
  output logic                  pready,
  output logic                  pslverr
);
  import scurve_pkg::*;

  logic       inj_edge;
  logic [2:0] trig_edge;
  logic       start;
  count_t     cpt_max;
  logic       busy;
  logic       done;
  logic       wr_en;
  count_t     wr_data;
  logic       full;
  logic       rd_en;
  count_t     rd_data;
  logic       empty;
  level_t     level;

  // Injection clock idles low and counts on its rising edge
  pulse_sync #(.FALLING(1'b0)) u_sync_inj (
    .clk_n      (clk_n),
    .reset_n    (reset_n),
    .async_in   (ext_clk),
    .edge_pulse (inj_edge)
  );

  // Discriminator outputs are active low
  pulse_sync #(.FALLING(1'b1)) u_sync_trig0 (
    .clk_n      (clk_n),
    .reset_n    (reset_n),
    .async_in   (trigger0b),
    .edge_pulse (trig_edge[0])
  );

  pulse_sync #(.FALLING(1'b1)) u_sync_trig1 (
    .clk_n      (clk_n),
    .reset_n    (reset_n),
    .async_in   (trigger1b),
    .edge_pulse (trig_edge[1])
  );

  pulse_sync #(.FALLING(1'b1)) u_sync_trig2 (
    .clk_n      (clk_n),
    .reset_n    (reset_n),
    .async_in   (trigger2b),
    .edge_pulse (trig_edge[2])
  );

  scurve_counter u_counter (
    .clk_n     (clk_n),
    .reset_n   (reset_n),
    .start     (start),
    .cpt_max   (cpt_max),
    .inj_edge  (inj_edge),
    .trig_edge (trig_edge),
    .full      (full),
    .busy      (busy),
    .done      (done),
    .wr_en     (wr_en),
    .wr_data   (wr_data)
  );

  scurve_fifo u_fifo (
    .clk_n   (clk_n),
    .reset_n (reset_n),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .full    (full),
    .empty   (empty),
    .level   (level)
  );

  scurve_apb_regs u_regs (
    .clk_n   (clk_n),
    .reset_n (reset_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .busy    (busy),
    .done    (done),
    .rd_data (rd_data),
    .empty   (empty),
    .level   (level),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .cpt_max (cpt_max),
    .rd_en   (rd_en)
  );

endmodule

`default_nettype wire

//--- verification/scurve_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scurve_tb;
  import scurve_pkg::*;

  localparam int          CLK_PERIOD     = 20;
  localparam int          SAMPLE_DELAY   = CLK_PERIOD / 4;
  localparam int          EXT_PERIOD     = 40;
  localparam int          GUARD          = 4;
  localparam int          START_PHASE    = 20;
  localparam int          NUM_MEAS       = 8;
  localparam int          TIMEOUT_CYCLES = 5000 * NUM_MEAS + 2000;
  localparam int unsigned SEED           = 32'hfd18;

  logic        clk_n;
  logic        reset_n;
  logic        ext_clk;
  logic [2:0]  trig_b;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;

  // Shared between the stimulus process and the APB sequence
  int unsigned ext_phase;
  int unsigned req_count;
  count_t      req_max;
  count_t      exp_q [$];
  int          exp_rd;

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clock_gen (
    .clk_n   (clk_n),
    .reset_n (reset_n)
  );

  scurve_top DUT (
    .clk_n     (clk_n),
    .reset_n   (reset_n),
    .ext_clk   (ext_clk),
    .trigger0b (trig_b[0]),
    .trigger1b (trig_b[1]),
    .trigger2b (trig_b[2]),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      abort_run($sformatf("ERR %s = 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  a_pready_on_access: assert property (
    @(posedge clk_n) disable iff (!reset_n) (psel && penable) |-> pready
  ) else abort_run("pready was low in an APB access phase");

  // Trigger edges stay clear of the injection edge and the start access
  function automatic bit trig_allowed(input int unsigned phase);
    return (phase >= GUARD) && (phase <= EXT_PERIOD - GUARD) &&
           ((phase + GUARD <= START_PHASE) || (phase >= START_PHASE + GUARD));
  endfunction

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(negedge clk_n);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_n);
    penable = 1'b1;
    @(negedge clk_n);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(negedge clk_n);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_n);
    penable = 1'b1;
    // Sample mid low phase, well before the pop takes effect
    #(SAMPLE_DELAY);
    data = prdata;
    err  = pslverr;
    @(negedge clk_n);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_and_check(input apb_addr_t addr, input apb_data_t exp);
    apb_data_t data;
    logic      err;
    apb_read(addr, data, err);
    check_value("prdata", data, exp);
    check_value("pslverr", {31'b0, err}, 32'h0);
  endtask

  task automatic check_data_word();
    apb_data_t data;
    logic      err;
    apb_read(ADDR_DATA, data, err);
    if (exp_rd >= exp_q.size()) begin
      abort_run("A DATA read returned a word that the reference model never produced");
    end else begin
      check_value("prdata", data, {16'b0, exp_q[exp_rd]});
      check_value("pslverr", {31'b0, err}, 32'h0);
      exp_rd++;
    end
  endtask

  task automatic set_cpt_max(input count_t value);
    apb_write(ADDR_CPT_MAX, {16'b0, value});
    req_max = value;
  endtask

  // Start access lands at START_PHASE of the injection period
  task automatic start_measure(input bit accepted);
    @(posedge clk_n);
    while (ext_phase != START_PHASE - 2) @(posedge clk_n);
    apb_write(ADDR_CTRL, 32'h1);
    if (accepted) begin
      req_count++;
    end
  endtask

  task automatic wait_done();
    apb_data_t data;
    logic      err;
    data = '0;
    while (data[1] == 1'b0) begin
      apb_read(ADDR_CTRL, data, err);
    end
  endtask

  task automatic wait_level(input level_t target);
    apb_data_t data;
    logic      err;
    data = '0;
    while (data[7:4] != target) begin
      apb_read(ADDR_STATUS, data, err);
    end
  endtask

  task automatic clear_done();
    apb_write(ADDR_CTRL, 32'h2);
  endtask

  task automatic run_measurement(input count_t value);
    set_cpt_max(value);
    start_measure(1'b1);
    wait_done();
    // Done set, busy already low
    read_and_check(ADDR_CTRL, 32'h2);
    clear_done();
  endtask

  // Injection clock, trigger pulses and the reference count
  initial begin : stimulus
    int unsigned low_left [3];
    int unsigned seen_req;
    count_t      inj_seen;
    count_t      win_max;
    count_t      model_cnt [3];
    logic        window_open;
    ext_phase   = EXT_PERIOD - 1;
    ext_clk     = 1'b0;
    trig_b      = 3'b111;
    seen_req    = 0;
    inj_seen    = '0;
    win_max     = '0;
    window_open = 1'b0;
    for (int i = 0; i < 3; i++) begin
      low_left[i]  = 0;
      model_cnt[i] = '0;
    end
    forever begin
      @(negedge clk_n);
      ext_phase = (ext_phase + 1) % EXT_PERIOD;
      ext_clk   = (ext_phase < EXT_PERIOD / 2);
      if (req_count != seen_req) begin
        seen_req = req_count;
        if (req_max == '0) begin
          repeat (3) exp_q.push_back('0);
        end else begin
          window_open = 1'b1;
          inj_seen    = '0;
          win_max     = req_max;
          for (int i = 0; i < 3; i++) model_cnt[i] = '0;
        end
      end
      // Window closes on the cpt_max-th rising edge
      if (window_open && ext_phase == 0) begin
        inj_seen++;
        if (inj_seen == win_max) begin
          window_open = 1'b0;
          for (int i = 0; i < 3; i++) exp_q.push_back(model_cnt[i]);
        end
      end
      for (int i = 0; i < 3; i++) begin
        if (low_left[i] != 0) begin
          low_left[i]--;
          if (low_left[i] == 0) trig_b[i] = 1'b1;
        end else if (trig_b[i] && trig_allowed(ext_phase) && ($urandom % 6 == 0)) begin
          trig_b[i]   = 1'b0;
          low_left[i] = $urandom_range(1, 3);
          if (window_open) model_cnt[i]++;
        end
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_n);
      cycles++;
    end
    abort_run($sformatf("Timeout after %0d cycles, the run hung waiting on the DUT", cycles));
  end

  initial begin : sequence_main
    apb_data_t data;
    logic      err;
    count_t    max_a;
    count_t    max_b;
    void'($urandom(SEED));
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    req_count = 0;
    req_max   = '0;
    exp_rd    = 0;
    @(posedge reset_n);

    // Reset values
    read_and_check(ADDR_CTRL, 32'h0);
    read_and_check(ADDR_CPT_MAX, 32'd100);
    read_and_check(ADDR_STATUS, 32'h01);

    // Single measurement of five injections
    run_measurement(16'd5);
    read_and_check(ADDR_CTRL, 32'h0);
    read_and_check(ADDR_STATUS, 32'h30);
    repeat (3) check_data_word();

    // Two measurements back to back, read out afterwards
    max_a = count_t'($urandom_range(1, 20));
    max_b = count_t'($urandom_range(1, 20));
    if (max_b == max_a) max_b = max_a + 16'd1;
    run_measurement(max_a);
    run_measurement(max_b);
    read_and_check(ADDR_STATUS, 32'h60);
    repeat (6) check_data_word();
    read_and_check(ADDR_STATUS, 32'h01);

    // Third result stalls on a full FIFO
    run_measurement(count_t'($urandom_range(1, 10)));
    run_measurement(count_t'($urandom_range(1, 10)));
    set_cpt_max(count_t'($urandom_range(1, 10)));
    start_measure(1'b1);
    wait_level(4'd8);
    repeat (10) @(negedge clk_n);
    read_and_check(ADDR_CTRL, 32'h1);
    read_and_check(ADDR_STATUS, 32'h80);
    check_data_word();
    wait_done();
    clear_done();
    repeat (8) check_data_word();
    read_and_check(ADDR_STATUS, 32'h01);

    // Error responses and a start while busy
    apb_read(ADDR_DATA, data, err);
    check_value("prdata", data, 32'h0);
    check_value("pslverr", {31'b0, err}, 32'h1);
    apb_read(4'h2, data, err);
    check_value("prdata", data, 32'h0);
    check_value("pslverr", {31'b0, err}, 32'h1);
    set_cpt_max(16'd6);
    start_measure(1'b1);
    repeat (50) @(posedge clk_n);
    start_measure(1'b0);
    read_and_check(ADDR_CTRL, 32'h1);
    wait_done();
    clear_done();
    read_and_check(ADDR_STATUS, 32'h30);
    repeat (3) check_data_word();
    read_and_check(ADDR_STATUS, 32'h01);

    // Empty window
    run_measurement(16'd0);
    read_and_check(ADDR_STATUS, 32'h30);
    repeat (3) check_data_word();
    read_and_check(ADDR_STATUS, 32'h01);

    if (exp_rd != exp_q.size()) begin
      abort_run("Expected result words were left unread at the end of the run");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_n,
  output logic reset_n
);

  initial begin
    clk_n = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_n = ~clk_n;
    end
  end

  // Release on a falling edge, like every other DUT input
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_n);
    @(negedge clk_n);
    reset_n = 1'b1;
  end

endmodule

`default_nettype wire
